// ==== design/trellisPkg.sv ====
//--------------------------------------------------------------------------
// SOQPSK trellis front end shared definitions
// widths, matched filter taps, register map and DAC source codes
//--------------------------------------------------------------------------

`default_nettype none

package trellisPkg;

   // sample and filter datapath
   localparam int sampleW  = 18;
   localparam int fracBits = 17;

   // branch metrics handed to the decoder
   localparam int rotBits = 10;
   localparam int numRot  = 4;
   localparam int numFilt = 3;
   localparam int branchW = numFilt * numRot * 2 * rotBits;

   typedef logic signed [sampleW-1:0] sampleT;

   // two-tap matched filter, Q1.17
   localparam logic signed [sampleW-1:0] coefA = 18'sd117634;
   localparam logic signed [sampleW-1:0] coefB = 18'sd57812;

   // register map
   localparam logic [12:0] decayAddr  = 13'h0004;
   localparam logic [7:0]  decayReset = 8'hff;

   // monitor DAC source select
   typedef enum logic [3:0] {
      dacI     = 4'd0,
      dacQ     = 4'd1,
      dacPhErr = 4'd2,
      dacIndex = 4'd3
   } dacSelT;

endpackage

`default_nettype wire

// ==== design/mfPairIf.sv ====
//--------------------------------------------------------------------------
// plus and minus matched filter outputs, source to rotation bank
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

interface mfPairIf;

   trellisPkg::sampleT plusI;
   trellisPkg::sampleT plusQ;
   trellisPkg::sampleT minusI;
   trellisPkg::sampleT minusQ;

   modport source (
      output plusI, plusQ, minusI, minusQ
   );

   modport sink (
      input plusI, plusQ, minusI, minusQ
   );

endinterface

`default_nettype wire

// ==== design/mfPlusMinus.sv ====
//--------------------------------------------------------------------------
// SOQPSK two-tap matched filters, plus and minus branches
// a*s(n) +/- b*j*s(n-1), truncated and saturated to the sample width
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mfPlusMinus (
   input  wire logic               clk,
   input  wire logic               rstN,
   input  wire logic               sym2xEn,
   input  wire trellisPkg::sampleT heldI,
   input  wire trellisPkg::sampleT heldQ,
   mfPairIf.source                 mf
);

   // one tap times one sample, scaled back by the coefficient fraction
   function automatic logic signed [trellisPkg::sampleW:0] tap(
      input logic signed [trellisPkg::sampleW-1:0] coef,
      input logic signed [trellisPkg::sampleW-1:0] s
   );
      logic signed [2*trellisPkg::sampleW-1:0] p;
      p = coef * s;
      return p[trellisPkg::fracBits+trellisPkg::sampleW:trellisPkg::fracBits];
   endfunction

   // clip a sum back into the sample range
   function automatic trellisPkg::sampleT sat(
      input logic signed [trellisPkg::sampleW+1:0] v
   );
      if (v[trellisPkg::sampleW+1:trellisPkg::sampleW-1] != {3{v[trellisPkg::sampleW+1]}}) begin
         if (v[trellisPkg::sampleW+1])
            return {1'b1, {(trellisPkg::sampleW-1){1'b0}}};
         else
            return {1'b0, {(trellisPkg::sampleW-1){1'b1}}};
      end
      return v[trellisPkg::sampleW-1:0];
   endfunction

   trellisPkg::sampleT prevI;
   trellisPkg::sampleT prevQ;

   logic signed [trellisPkg::sampleW:0]   aI, aQ, bI, bQ;
   logic signed [trellisPkg::sampleW+1:0] plusISum, plusQSum, minusISum, minusQSum;

   assign aI = tap(trellisPkg::coefA, heldI);
   assign aQ = tap(trellisPkg::coefA, heldQ);
   assign bI = tap(trellisPkg::coefB, prevI);
   assign bQ = tap(trellisPkg::coefB, prevQ);

   // j*(I,Q) = (-Q,I) on the delayed tap
   assign plusISum  = aI - bQ;
   assign plusQSum  = aQ + bI;
   assign minusISum = aI + bQ;
   assign minusQSum = aQ - bI;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         prevI     <= '0;
         prevQ     <= '0;
         mf.plusI  <= '0;
         mf.plusQ  <= '0;
         mf.minusI <= '0;
         mf.minusQ <= '0;
      end else if (sym2xEn) begin
         prevI     <= heldI;
         prevQ     <= heldQ;
         mf.plusI  <= sat(plusISum);
         mf.plusQ  <= sat(plusQSum);
         mf.minusI <= sat(minusISum);
         mf.minusQ <= sat(minusQSum);
      end
   end

endmodule

`default_nettype wire

// ==== design/mfZeroDelay.sv ====
//--------------------------------------------------------------------------
// zero matched filter, unit gain, one enable of delay
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mfZeroDelay (
   input  wire logic               clk,
   input  wire logic               rstN,
   input  wire logic               sym2xEn,
   input  wire trellisPkg::sampleT heldI,
   input  wire trellisPkg::sampleT heldQ,
   output      trellisPkg::sampleT zeroI,
   output      trellisPkg::sampleT zeroQ
);

   // lines up with the plus/minus filter registers
   always_ff @(posedge clk) begin
      if (!rstN) begin
         zeroI <= '0;
         zeroQ <= '0;
      end else if (sym2xEn) begin
         zeroI <= heldI;
         zeroQ <= heldQ;
      end
   end

endmodule

`default_nettype wire

// ==== design/rotationBank.sv ====
//--------------------------------------------------------------------------
// quarter-turn rotations of the zero, plus and minus filter outputs
// packed into one registered branch vector for the decoder
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rotationBank (
   input  wire logic                          clk,
   input  wire logic                          rstN,
   input  wire logic                          sym2xEn,
   input  wire trellisPkg::sampleT            zeroI,
   input  wire trellisPkg::sampleT            zeroQ,
   mfPairIf.sink                              mf,
   output      logic [trellisPkg::branchW-1:0] branch
);

   // returns {imag, real}; negation wraps in rotBits
   function automatic logic [2*trellisPkg::rotBits-1:0] rotate(
      input logic [trellisPkg::rotBits-1:0] re,
      input logic [trellisPkg::rotBits-1:0] im,
      input int                             r
   );
      case (r)
         0:       return {im, re};
         1:       return {-re, im};
         2:       return {-im, -re};
         default: return {re, -im};
      endcase
   endfunction

   logic [trellisPkg::rotBits-1:0]  compRe [trellisPkg::numFilt];
   logic [trellisPkg::rotBits-1:0]  compIm [trellisPkg::numFilt];
   logic [trellisPkg::branchW-1:0] branchNext;

   // zero path is halved, sign bit repeated
   assign compRe[0] = {zeroI[trellisPkg::sampleW-1],
                       zeroI[trellisPkg::sampleW-1 -: trellisPkg::rotBits-1]};
   assign compIm[0] = {zeroQ[trellisPkg::sampleW-1],
                       zeroQ[trellisPkg::sampleW-1 -: trellisPkg::rotBits-1]};
   assign compRe[1] = mf.plusI[trellisPkg::sampleW-1 -: trellisPkg::rotBits];
   assign compIm[1] = mf.plusQ[trellisPkg::sampleW-1 -: trellisPkg::rotBits];
   assign compRe[2] = mf.minusI[trellisPkg::sampleW-1 -: trellisPkg::rotBits];
   assign compIm[2] = mf.minusQ[trellisPkg::sampleW-1 -: trellisPkg::rotBits];

   // filter outermost, then rotation, real in the low half
   always_comb begin
      for (int f = 0; f < trellisPkg::numFilt; f++) begin
         for (int r = 0; r < trellisPkg::numRot; r++) begin
            branchNext[(f*trellisPkg::numRot + r)*2*trellisPkg::rotBits +: 2*trellisPkg::rotBits]
               = rotate(compRe[f], compIm[f], r);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN)
         branch <= '0;
      else if (sym2xEn)
         branch <= branchNext;
   end

endmodule

`default_nettype wire

// ==== design/trellisMonitor.sv ====
//--------------------------------------------------------------------------
// trellis monitor with phase error scaler, 2x enable and DAC source muxes
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module trellisMonitor (
   input  wire logic                        clk,
   input  wire logic                        rstN,
   input  wire logic                        sym2xEn,
   input  wire trellisPkg::sampleT          heldI,
   input  wire trellisPkg::sampleT          heldQ,
   input  wire logic [9:0]                  phaseError,
   input  wire logic [1:0]                  index,
   input  wire logic [3:0]                  dac0Select,
   input  wire logic [3:0]                  dac1Select,
   input  wire logic [3:0]                  dac2Select,
   output      logic [7:0]                  phaseErrorScaled,
   output      logic                        sym2xEnOut,
   output      logic                        dac0Sync,
   output      logic [trellisPkg::sampleW-1:0] dac0Data,
   output      logic                        dac1Sync,
   output      logic [trellisPkg::sampleW-1:0] dac1Data,
   output      logic                        dac2Sync,
   output      logic [trellisPkg::sampleW-1:0] dac2Data
);

   //------------------------------------------------------------------------
   // phase error scaling in two enable stages
   //------------------------------------------------------------------------
   logic [6:0] dataBits;
   logic       satPos;
   logic       satNeg;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         dataBits         <= '0;
         satPos           <= 1'b0;
         satNeg           <= 1'b0;
         phaseErrorScaled <= '0;
      end else if (sym2xEn) begin
         dataBits <= phaseError[6:0];
         satPos   <= !phaseError[9] && (phaseError[9:6] != 4'b0000);
         satNeg   <=  phaseError[9] && (phaseError[9:6] != 4'b1111);
         if (satPos)
            phaseErrorScaled <= 8'h7f;
         else if (satNeg)
            phaseErrorScaled <= 8'h81;
         else
            phaseErrorScaled <= {dataBits, 1'b0};
      end
   end

   //------------------------------------------------------------------------
   // 2x enable for the line decoder with 3+ clocks between enables
   //------------------------------------------------------------------------
   logic sym2xEnDly;

   always_ff @(posedge clk) begin
      if (!rstN)
         sym2xEnDly <= 1'b0;
      else
         sym2xEnDly <= sym2xEn;
   end

   assign sym2xEnOut = sym2xEn | sym2xEnDly;

   //------------------------------------------------------------------------
   // DAC channels
   //------------------------------------------------------------------------
   // unknown codes fall back to phase error
   function automatic logic [trellisPkg::sampleW-1:0] dacSource(input logic [3:0] sel);
      case (trellisPkg::dacSelT'(sel))
         trellisPkg::dacI:     return heldI;
         trellisPkg::dacQ:     return heldQ;
         trellisPkg::dacIndex: return {4'b0, index, 12'b0};
         default:              return {phaseError, 8'b0};
      endcase
   endfunction

   always_ff @(posedge clk) begin
      if (!rstN) begin
         dac0Data <= '0;
         dac1Data <= '0;
         dac2Data <= '0;
      end else begin
         dac0Data <= dacSource(dac0Select);
         dac1Data <= dacSource(dac1Select);
         dac2Data <= dacSource(dac2Select);
      end
   end

   // all channels strobe with the delayed sample enable
   assign dac0Sync = sym2xEnDly;
   assign dac1Sync = sym2xEnDly;
   assign dac2Sync = sym2xEnDly;

endmodule

`default_nettype wire

// ==== design/trellisRegs.sv ====
//--------------------------------------------------------------------------
// trellis control register: decay factor write and readback
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module trellisRegs (
   input  wire logic        clk,
   input  wire logic        rstN,
   input  wire logic        cs,
   input  wire logic        wr,
   input  wire logic [12:0] addr,
   input  wire logic [31:0] din,
   output      logic [31:0] dout,
   output      logic [7:0]  decayFactor
);

   logic decaySel;

   assign decaySel = cs && (addr == trellisPkg::decayAddr);

   always_ff @(posedge clk) begin
      if (!rstN)
         decayFactor <= trellisPkg::decayReset;
      else if (decaySel && wr)
         decayFactor <= din[7:0];
   end

   // unmatched reads return zero
   assign dout = decaySel ? {24'b0, decayFactor} : 32'b0;

endmodule

`default_nettype wire

// ==== design/trellisSoqpsk.sv ====
//--------------------------------------------------------------------------
// SOQPSK trellis demodulator front end
// sample hold, matched filters, rotation bank, monitor and registers
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module trellisSoqpsk (
   input  wire logic                          clk,
   input  wire logic                          rstN,
   input  wire logic                          sym2xEn,
   input  wire trellisPkg::sampleT            iIn,
   input  wire trellisPkg::sampleT            qIn,
   input  wire logic [9:0]                    phaseError,
   input  wire logic [1:0]                    index,
   input  wire logic                          cs,
   input  wire logic                          wr,
   input  wire logic [12:0]                   addr,
   input  wire logic [31:0]                   din,
   input  wire logic [3:0]                    dac0Select,
   input  wire logic [3:0]                    dac1Select,
   input  wire logic [3:0]                    dac2Select,
   output      logic [trellisPkg::branchW-1:0] branch,
   output      logic [7:0]                    phaseErrorScaled,
   output      logic [7:0]                    decayFactor,
   output      logic [31:0]                   dout,
   output      logic                          sym2xEnOut,
   output      logic                          dac0Sync,
   output      logic [17:0]                   dac0Data,
   output      logic                          dac1Sync,
   output      logic [17:0]                   dac1Data,
   output      logic                          dac2Sync,
   output      logic [17:0]                   dac2Data
);

   //------------------------------------------------------------------------
   // input sample hold
   //------------------------------------------------------------------------
   trellisPkg::sampleT heldI;
   trellisPkg::sampleT heldQ;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         heldI <= '0;
         heldQ <= '0;
      end else if (sym2xEn) begin
         heldI <= iIn;
         heldQ <= qIn;
      end
   end

   //------------------------------------------------------------------------
   // filter chain
   //------------------------------------------------------------------------
   mfPairIf mfBus ();

   trellisPkg::sampleT zeroI;
   trellisPkg::sampleT zeroQ;

   mfPlusMinus mfPm (
      .clk     (clk),
      .rstN    (rstN),
      .sym2xEn (sym2xEn),
      .heldI   (heldI),
      .heldQ   (heldQ),
      .mf      (mfBus.source)
   );

   mfZeroDelay mfZero (
      .clk     (clk),
      .rstN    (rstN),
      .sym2xEn (sym2xEn),
      .heldI   (heldI),
      .heldQ   (heldQ),
      .zeroI   (zeroI),
      .zeroQ   (zeroQ)
   );

   rotationBank rotBank (
      .clk     (clk),
      .rstN    (rstN),
      .sym2xEn (sym2xEn),
      .zeroI   (zeroI),
      .zeroQ   (zeroQ),
      .mf      (mfBus.sink),
      .branch  (branch)
   );

   //------------------------------------------------------------------------
   // monitor and control register
   //------------------------------------------------------------------------
   trellisMonitor monitor (
      .clk              (clk),
      .rstN             (rstN),
      .sym2xEn          (sym2xEn),
      .heldI            (heldI),
      .heldQ            (heldQ),
      .phaseError       (phaseError),
      .index            (index),
      .dac0Select       (dac0Select),
      .dac1Select       (dac1Select),
      .dac2Select       (dac2Select),
      .phaseErrorScaled (phaseErrorScaled),
      .sym2xEnOut       (sym2xEnOut),
      .dac0Sync         (dac0Sync),
      .dac0Data         (dac0Data),
      .dac1Sync         (dac1Sync),
      .dac1Data         (dac1Data),
      .dac2Sync         (dac2Sync),
      .dac2Data         (dac2Data)
   );

   trellisRegs regs (
      .clk         (clk),
      .rstN        (rstN),
      .cs          (cs),
      .wr          (wr),
      .addr        (addr),
      .din         (din),
      .dout        (dout),
      .decayFactor (decayFactor)
   );

endmodule

`default_nettype wire

// ==== sim/trellisSoqpsk_props.sv ====
//--------------------------------------------------------------------------
// trellis front end timing properties, bound into the top level
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module trellisSoqpskProps (
   input wire logic clk,
   input wire logic rstN,
   input wire logic sym2xEn,
   input wire logic sym2xEnOut,
   input wire logic dac0Sync,
   input wire logic dac1Sync,
   input wire logic dac2Sync
);

   // 2x enable covers the enable cycle and the one after
   enOutShape: assert property (@(posedge clk) disable iff (!rstN)
      sym2xEnOut == (sym2xEn || $past(sym2xEn)))
      else $error("sym2xEnOut is not the enable stretched by one clock");

   // every DAC strobe trails the sample enable by one clock
   dacSyncDelay: assert property (@(posedge clk) disable iff (!rstN)
      (dac0Sync == $past(sym2xEn)) && (dac1Sync == $past(sym2xEn))
      && (dac2Sync == $past(sym2xEn)))
      else $error("a DAC sync does not follow the delayed enable");

   // the 2x enable merges pulses that come closer than 3 clocks
   enSpacing: assert property (@(posedge clk) disable iff (!rstN)
      sym2xEn |-> (!$past(sym2xEn) && !$past(sym2xEn, 2)))
      else $error("two sample enables less than 3 clocks apart");

endmodule

bind trellisSoqpsk trellisSoqpskProps props (
   .clk        (clk),
   .rstN       (rstN),
   .sym2xEn    (sym2xEn),
   .sym2xEnOut (sym2xEnOut),
   .dac0Sync   (dac0Sync),
   .dac1Sync   (dac1Sync),
   .dac2Sync   (dac2Sync)
);

`default_nettype wire

// ==== sim/trellisSoqpskTb.sv ====
//--------------------------------------------------------------------------
// testbench for the SOQPSK trellis front end
// random samples and bus traffic checked against a cycle model
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module trellisSoqpskTb;

   localparam int numEnables = 400;
   // 8 clocks per enable and a reset margin
   localparam int timeoutNs = (numEnables * 8 + 40) * 40;

   logic clk;
   logic rstN;
   logic sym2xEn;
   trellisPkg::sampleT iIn;
   trellisPkg::sampleT qIn;
   logic [9:0] phaseError;
   logic [1:0] index;
   logic cs;
   logic wr;
   logic [12:0] addr;
   logic [31:0] din;
   logic [3:0] dac0Select;
   logic [3:0] dac1Select;
   logic [3:0] dac2Select;
   logic [trellisPkg::branchW-1:0] branch;
   logic [7:0] phaseErrorScaled;
   logic [7:0] decayFactor;
   logic [31:0] dout;
   logic sym2xEnOut;
   logic dac0Sync;
   logic [17:0] dac0Data;
   logic dac1Sync;
   logic [17:0] dac1Data;
   logic dac2Sync;
   logic [17:0] dac2Data;

   // model state
   trellisPkg::sampleT histI[$];
   trellisPkg::sampleT histQ[$];
   trellisPkg::sampleT mHeldI;
   trellisPkg::sampleT mHeldQ;
   logic [7:0] mPeStage;
   logic [7:0] mPeOut;
   logic [7:0] mDecay;
   logic [17:0] mDac [3];
   logic mSyncDly;
   logic [trellisPkg::branchW-1:0] expBranch;
   int enCount;
   int gapLeft;

   trellisSoqpsk DUT (
      .clk (clk), .rstN (rstN), .sym2xEn (sym2xEn), .iIn (iIn), .qIn (qIn),
      .phaseError (phaseError), .index (index), .cs (cs), .wr (wr),
      .addr (addr), .din (din), .dac0Select (dac0Select),
      .dac1Select (dac1Select), .dac2Select (dac2Select), .branch (branch),
      .phaseErrorScaled (phaseErrorScaled), .decayFactor (decayFactor),
      .dout (dout), .sym2xEnOut (sym2xEnOut),
      .dac0Sync (dac0Sync), .dac0Data (dac0Data),
      .dac1Sync (dac1Sync), .dac1Data (dac1Data),
      .dac2Sync (dac2Sync), .dac2Data (dac2Data)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      #(timeoutNs);
      $display("watchdog expired before all sample enables were run");
      $display("TEST FAILED");
      $fatal(1, "timeout");
   end

   task automatic expectEqual(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
         $display("TEST FAILED");
         $fatal(1, "stopping on first error");
      end
   endtask

   //------------------------------------------------------------------------
   // reference model
   //------------------------------------------------------------------------
   function automatic trellisPkg::sampleT histAt(input bit isQ, input int n);
      if (n < 0)
         return '0;
      return isQ ? histQ[n] : histI[n];
   endfunction

   function automatic int tapScale(input trellisPkg::sampleT coef,
                                   input trellisPkg::sampleT s);
      longint p;
      p = longint'(coef) * longint'(s);
      return int'(p >>> trellisPkg::fracBits);
   endfunction

   function automatic int clip18(input int v);
      if (v > 131071)
         return 131071;
      if (v < -131072)
         return -131072;
      return v;
   endfunction

   function automatic logic [9:0] top10(input int v, input int shift);
      int t;
      t = v >>> shift;
      return t[9:0];
   endfunction

   function automatic logic [9:0] neg10(input logic [9:0] x);
      return ~x + 10'd1;
   endfunction

   // branch after enable k from samples k-2 and k-3
   function automatic logic [trellisPkg::branchW-1:0] modelBranch(input int k);
      trellisPkg::sampleT cI, cQ, pI, pQ;
      int aI, aQ, bI, bQ, base;
      logic [9:0] re [3];
      logic [9:0] im [3];
      logic [trellisPkg::branchW-1:0] b;
      cI = histAt(1'b0, k - 2);
      cQ = histAt(1'b1, k - 2);
      pI = histAt(1'b0, k - 3);
      pQ = histAt(1'b1, k - 3);
      aI = tapScale(trellisPkg::coefA, cI);
      aQ = tapScale(trellisPkg::coefA, cQ);
      bI = tapScale(trellisPkg::coefB, pI);
      bQ = tapScale(trellisPkg::coefB, pQ);
      // zero path halved against full-scale plus and minus
      re[0] = top10(int'(cI), 9);
      im[0] = top10(int'(cQ), 9);
      re[1] = top10(clip18(aI - bQ), 8);
      im[1] = top10(clip18(aQ + bI), 8);
      re[2] = top10(clip18(aI + bQ), 8);
      im[2] = top10(clip18(aQ - bI), 8);
      b = '0;
      for (int f = 0; f < 3; f++) begin
         for (int r = 0; r < 4; r++) begin
            base = (f * 4 + r) * 20;
            case (r)
               0: begin
                  b[base +: 10]      = re[f];
                  b[base + 10 +: 10] = im[f];
               end
               1: begin
                  b[base +: 10]      = im[f];
                  b[base + 10 +: 10] = neg10(re[f]);
               end
               2: begin
                  b[base +: 10]      = neg10(re[f]);
                  b[base + 10 +: 10] = neg10(im[f]);
               end
               default: begin
                  b[base +: 10]      = neg10(im[f]);
                  b[base + 10 +: 10] = re[f];
               end
            endcase
         end
      end
      return b;
   endfunction

   function automatic logic [7:0] scalePhase(input logic [9:0] pe);
      int v, t;
      v = int'($signed(pe));
      if (v > 63)
         return 8'h7f;
      if (v < -64)
         return 8'h81;
      t = v * 2;
      return t[7:0];
   endfunction

   // codes 0 I, 1 Q, 3 index, anything else phase error
   function automatic logic [17:0] dacModel(input logic [3:0] sel);
      case (sel)
         4'd0:    return mHeldI;
         4'd1:    return mHeldQ;
         4'd3:    return 18'(index) << 12;
         default: return {phaseError, 8'h00};
      endcase
   endfunction

   // advance the model by the clock edge that just passed
   task automatic modelEdge();
      mDac[0] = dacModel(dac0Select);
      mDac[1] = dacModel(dac1Select);
      mDac[2] = dacModel(dac2Select);
      mSyncDly = sym2xEn;
      if (cs && wr && addr == trellisPkg::decayAddr)
         mDecay = din[7:0];
      if (sym2xEn) begin
         histI.push_back(iIn);
         histQ.push_back(qIn);
         mHeldI = iIn;
         mHeldQ = qIn;
         mPeOut = mPeStage;
         mPeStage = scalePhase(phaseError);
         expBranch = modelBranch(enCount);
         enCount++;
      end
   endtask

   //------------------------------------------------------------------------
   // checks and stimulus
   //------------------------------------------------------------------------
   task automatic checkEdge();
      int base;
      for (int f = 0; f < 3; f++) begin
         for (int r = 0; r < 4; r++) begin
            base = (f * 4 + r) * 20;
            expectEqual(64'(branch[base +: 10]), 64'(expBranch[base +: 10]),
                        $sformatf("branch filter %0d rotation %0d real", f, r));
            expectEqual(64'(branch[base + 10 +: 10]), 64'(expBranch[base + 10 +: 10]),
                        $sformatf("branch filter %0d rotation %0d imag", f, r));
         end
      end
      expectEqual(64'(phaseErrorScaled), 64'(mPeOut), "phaseErrorScaled");
      expectEqual(64'(decayFactor), 64'(mDecay), "decayFactor");
      expectEqual(64'(dac0Data), 64'(mDac[0]), "dac0Data");
      expectEqual(64'(dac1Data), 64'(mDac[1]), "dac1Data");
      expectEqual(64'(dac2Data), 64'(mDac[2]), "dac2Data");
      expectEqual(64'({dac2Sync, dac1Sync, dac0Sync}), 64'({3{mSyncDly}}), "dac syncs");
   endtask

   // combinational outputs after the new inputs settle
   task automatic checkComb();
      logic [31:0] expDout;
      expDout = (cs && addr == trellisPkg::decayAddr) ? {24'h0, mDecay} : 32'h0;
      expectEqual(64'(dout), 64'(expDout), "dout readback");
      expectEqual(64'(sym2xEnOut), 64'(sym2xEn | mSyncDly), "sym2xEnOut");
   endtask

   function automatic logic [9:0] directedPhase(input int n);
      case (n % 6)
         0:       return 10'h1ff;
         1:       return 10'h200;
         2:       return 10'h040;
         3:       return 10'h03f;
         4:       return 10'h3c0;
         default: return 10'h3bf;
      endcase
   endfunction

   function automatic logic [3:0] pickSelect();
      if ($urandom_range(0, 1) == 1)
         return 4'($urandom_range(0, 3));
      return 4'($urandom_range(0, 15));
   endfunction

   task automatic driveNext();
      if (gapLeft == 0) begin
         sym2xEn = 1'b1;
         gapLeft = $urandom_range(4, 7) - 1;
      end else begin
         sym2xEn = 1'b0;
         gapLeft--;
      end
      iIn = 18'($urandom);
      qIn = 18'($urandom);
      // saturation corners on every fifth enable
      if (sym2xEn && enCount % 5 == 0)
         phaseError = directedPhase(enCount / 5);
      else
         phaseError = 10'($urandom);
      index = 2'($urandom);
      dac0Select = pickSelect();
      dac1Select = pickSelect();
      dac2Select = pickSelect();
      cs = ($urandom_range(0, 3) != 0);
      wr = ($urandom_range(0, 3) == 0);
      addr = ($urandom_range(0, 1) == 1) ? trellisPkg::decayAddr : 13'($urandom);
      din = $urandom;
   endtask

   initial begin
      void'($urandom(53));
      rstN = 1'b0;
      sym2xEn = 1'b0;
      iIn = '0;
      qIn = '0;
      phaseError = '0;
      index = '0;
      cs = 1'b0;
      wr = 1'b0;
      addr = '0;
      din = '0;
      dac0Select = '0;
      dac1Select = '0;
      dac2Select = '0;
      mHeldI = '0;
      mHeldQ = '0;
      mPeStage = '0;
      mPeOut = '0;
      mDecay = trellisPkg::decayReset;
      mDac = '{default: '0};
      mSyncDly = 1'b0;
      expBranch = '0;
      enCount = 0;
      gapLeft = 2;
      repeat (8) @(negedge clk);

      // reset state
      expectEqual(64'(sym2xEnOut), 64'(0), "sym2xEnOut in reset");
      expectEqual(64'({dac2Sync, dac1Sync, dac0Sync}), 64'(0), "dac syncs in reset");
      expectEqual(64'(|branch), 64'(0), "branch in reset");
      expectEqual(64'(phaseErrorScaled), 64'(0), "phaseErrorScaled in reset");
      expectEqual(64'(decayFactor), 64'(trellisPkg::decayReset), "decayFactor in reset");
      expectEqual(64'(dac0Data | dac1Data | dac2Data), 64'(0), "dac data in reset");
      rstN = 1'b1;

      while (enCount < numEnables) begin
         @(negedge clk);
         modelEdge();
         checkEdge();
         driveNext();
         #1;
         checkComb();
      end

      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== trellisSoqpsk.f ====
design/trellisPkg.sv
design/mfPairIf.sv
design/mfPlusMinus.sv
design/mfZeroDelay.sv
design/rotationBank.sv
design/trellisMonitor.sv
design/trellisRegs.sv
design/trellisSoqpsk.sv
sim/trellisSoqpsk_props.sv
sim/trellisSoqpskTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= trellisSoqpskTb
FILELIST  ?= trellisSoqpsk.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJDIR)
